//--- mem_pkg.sv
package mem_pkg;

    // ****************************************
    // Data path widths
    // ****************************************

    parameter int XLEN   = 32;           // Data word width.
    parameter int LANES  = 4;            // Byte lanes per word.
    parameter int BYTE_W = 8;
    parameter int HALF_W = 16;
    parameter int HALVES = XLEN / HALF_W;

    // ****************************************
    // Load and store size codes (funct3)
    // ****************************************

    // Stores only use the three signed codes.
    parameter logic [2:0] F3_BYTE   = 3'b000;  // LB / SB.
    parameter logic [2:0] F3_HALF   = 3'b001;  // LH / SH.
    parameter logic [2:0] F3_WORD   = 3'b010;  // LW / SW / FLW / FSW.
    parameter logic [2:0] F3_BYTE_U = 3'b100;  // LBU.
    parameter logic [2:0] F3_HALF_U = 3'b101;  // LHU.

    // ****************************************
    // Memory word
    // ****************************************

    // One word as read back from the banks.
    // Byte k sits in lane k, half 1 covers lanes 3 and 2.
    typedef union packed {
        logic [LANES-1:0][BYTE_W-1:0]  bytes;
        logic [HALVES-1:0][HALF_W-1:0] halves;
    } mem_word_u;

endpackage

//--- pipe_pkg.sv
package pipe_pkg;

    import mem_pkg::*;

    // ****************************************
    // Execute stage result
    // ****************************************

    typedef struct packed {
        logic [XLEN-1:0] alu_out;       // Address for loads and stores.
        logic [XLEN-1:0] fp_result;
        logic [4:0]      write_addr;
        logic [4:0]      f_write_addr;
        logic [2:0]      funct3;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] store_data;    // Unaligned, in the low bits.
        logic            rd_src;        // Write back pc + 4.
        logic            mem_to_reg;
        logic            mem_write;
        logic            mem_read;
        logic            reg_write;
        logic            f_reg_write;
        logic            is_float;
    } exe_out_t;

    // ****************************************
    // EX/MEM register contents
    // ****************************************

    typedef struct packed {
        logic [XLEN-1:0] alu_out;
        logic [XLEN-1:0] fp_result;
        logic [4:0]      write_addr;
        logic [4:0]      f_write_addr;
        logic [2:0]      funct3;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] aligned_data;  // Store data moved to its lanes.
        logic [XLEN-1:0] write_mask;    // Active low, one bit per data bit.
        logic            rd_src;
        logic            mem_to_reg;
        logic            mem_write;
        logic            mem_read;
        logic            reg_write;
        logic            f_reg_write;
        logic            is_float;
    } exe_mem_t;

    // Write-back result.
    typedef struct packed {
        logic            reg_write;
        logic            f_reg_write;
        logic [4:0]      write_addr;
        logic [4:0]      f_write_addr;
        logic [XLEN-1:0] data;
    } wb_t;

endpackage

//--- exe_mem_reg.sv
`timescale 1ns/10ps

module exe_mem_reg
    import mem_pkg::*;
    import pipe_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  exe_out_t exe,
    output exe_mem_t mem_q
);

    localparam logic [XLEN-1:0] BYTE_ONES = {{(XLEN-BYTE_W){1'b0}}, {BYTE_W{1'b1}}};
    localparam logic [XLEN-1:0] HALF_ONES = {{(XLEN-HALF_W){1'b0}}, {HALF_W{1'b1}}};

    logic [1:0]      offset;
    logic            in_range;
    logic            store;
    logic [XLEN-1:0] aligned;
    logic [XLEN-1:0] mask_n;

    assign offset = exe.alu_out[1:0];

    // Stores past the last word are dropped instead of wrapping around.
    assign in_range = (exe.alu_out[XLEN-1:ADDR_WIDTH+2] == '0);
    assign store    = exe.mem_write & in_range;

    // ****************************************
    // Store lane alignment and write mask
    // ****************************************

    always_comb begin
        aligned = exe.store_data;
        mask_n  = '1;                                 // Nothing written.
        if (store) begin
            case (exe.funct3)
                F3_BYTE: begin
                    aligned = exe.store_data << (BYTE_W * offset);
                    mask_n  = ~(BYTE_ONES << (BYTE_W * offset));
                end
                F3_HALF: begin
                    // Bit 0 of the offset is ignored for halves.
                    aligned = exe.store_data << (HALF_W * offset[1]);
                    mask_n  = ~(HALF_ONES << (HALF_W * offset[1]));
                end
                default: begin                        // SW and FSW.
                    aligned = exe.store_data;
                    mask_n  = '0;
                end
            endcase
        end
    end

    // ****************************************
    // Pipeline register
    // ****************************************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_q            <= '0;
            mem_q.write_mask <= '1;
        end else begin
            mem_q.alu_out      <= exe.alu_out;
            mem_q.fp_result    <= exe.fp_result;
            mem_q.write_addr   <= exe.write_addr;
            mem_q.f_write_addr <= exe.f_write_addr;
            mem_q.funct3       <= exe.funct3;
            mem_q.pc           <= exe.pc;
            mem_q.aligned_data <= aligned;
            mem_q.write_mask   <= mask_n;
            mem_q.rd_src       <= exe.rd_src;
            mem_q.mem_to_reg   <= exe.mem_to_reg;
            mem_q.mem_write    <= store;
            mem_q.mem_read     <= exe.mem_read;
            mem_q.reg_write    <= exe.reg_write;
            mem_q.f_reg_write  <= exe.f_reg_write;
            mem_q.is_float     <= exe.is_float;
        end
    end

endmodule

//--- data_bank.sv
`timescale 1ns/10ps

module data_bank #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [7:0]            wmask_n,
    input  logic [7:0]            wdata,
    output logic [7:0]            rdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [7:0] mem [DEPTH];

    // ****************************************
    // Bit-masked write, read-first port
    // ****************************************

    always_ff @(posedge clk) begin
        if (we) begin
            // Only bits with a 0 mask bit take the new value.
            mem[addr] <= (mem[addr] & wmask_n) | (wdata & ~wmask_n);
        end
        rdata <= mem[addr];                           // Old contents on a write.
    end

endmodule

//--- load_format.sv
`timescale 1ns/10ps

module load_format
    import mem_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  exe_mem_t  mem_q,
    input  mem_word_u rdata,
    output wb_t       wb
);

    // Fields still needed once the bank read has landed.
    typedef struct packed {
        logic [XLEN-1:0] alu_out;
        logic [XLEN-1:0] fp_result;
        logic [XLEN-1:0] pc;
        logic [4:0]      write_addr;
        logic [4:0]      f_write_addr;
        logic [2:0]      funct3;
        logic            rd_src;
        logic            mem_to_reg;
        logic            reg_write;
        logic            f_reg_write;
        logic            is_float;
    } wb_ctl_t;

    wb_ctl_t           q;
    logic [BYTE_W-1:0] sel_byte;
    logic [HALF_W-1:0] sel_half;
    logic [XLEN-1:0]   load_data;

    // ****************************************
    // MEM/WB register
    // ****************************************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= '0;
        end else begin
            q.alu_out      <= mem_q.alu_out;
            q.fp_result    <= mem_q.fp_result;
            q.pc           <= mem_q.pc;
            q.write_addr   <= mem_q.write_addr;
            q.f_write_addr <= mem_q.f_write_addr;
            q.funct3       <= mem_q.funct3;
            q.rd_src       <= mem_q.rd_src;
            q.mem_to_reg   <= mem_q.mem_to_reg;
            q.reg_write    <= mem_q.reg_write;
            q.f_reg_write  <= mem_q.f_reg_write;
            q.is_float     <= mem_q.is_float;
        end
    end

    // ****************************************
    // Load extraction
    // ****************************************

    assign sel_byte = rdata.bytes[q.alu_out[1:0]];
    assign sel_half = rdata.halves[q.alu_out[1]];     // Bit 0 ignored.

    always_comb begin
        case (q.funct3)
            F3_BYTE:   load_data = {{(XLEN-BYTE_W){sel_byte[BYTE_W-1]}}, sel_byte};
            F3_HALF:   load_data = {{(XLEN-HALF_W){sel_half[HALF_W-1]}}, sel_half};
            F3_BYTE_U: load_data = XLEN'(sel_byte);
            F3_HALF_U: load_data = XLEN'(sel_half);
            default:   load_data = rdata;             // LW and FLW.
        endcase
    end

    // Write-back select, load data first.
    always_comb begin
        wb.reg_write    = q.reg_write;
        wb.f_reg_write  = q.f_reg_write;
        wb.write_addr   = q.write_addr;
        wb.f_write_addr = q.f_write_addr;
        if (q.mem_to_reg) begin
            wb.data = load_data;
        end else if (q.rd_src) begin
            wb.data = q.pc + XLEN'(4);                // Link address.
        end else if (q.is_float) begin
            wb.data = q.fp_result;
        end else begin
            wb.data = q.alu_out;
        end
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/10ps

module mem_stage
    import mem_pkg::*;
    import pipe_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  exe_out_t exe,
    output wb_t      wb
);

    exe_mem_t                     mem_q;
    logic [LANES-1:0][BYTE_W-1:0] lane_rdata;
    mem_word_u                    rd_word;

    // ****************************************
    // EX/MEM register
    // ****************************************

    exe_mem_reg #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_exe_mem_reg (
        .clk   (clk),
        .reset (reset),
        .exe   (exe),
        .mem_q (mem_q)
    );

    // ****************************************
    // Data memory, one bank per byte lane
    // ****************************************

    for (genvar i = 0; i < LANES; i++) begin : g_bank
        data_bank #(
            .ADDR_WIDTH (ADDR_WIDTH)
        ) i_data_bank (
            .clk     (clk),
            .we      (mem_q.mem_write),
            .addr    (mem_q.alu_out[ADDR_WIDTH+1:2]),  // Word index.
            .wmask_n (mem_q.write_mask[i*BYTE_W +: BYTE_W]),
            .wdata   (mem_q.aligned_data[i*BYTE_W +: BYTE_W]),
            .rdata   (lane_rdata[i])
        );
    end

    assign rd_word = lane_rdata;

    // MEM/WB register and load formatting.
    load_format i_load_format (
        .clk   (clk),
        .reset (reset),
        .mem_q (mem_q),
        .rdata (rd_word),
        .wb    (wb)
    );

endmodule

//--- tb_mem_stage.sv
`timescale 1ns/10ps

module tb_mem_stage
    import mem_pkg::*;
    import pipe_pkg::*;
();

    localparam int ADDR_WIDTH = 8;
    localparam int WORDS      = 2 ** ADDR_WIDTH;
    localparam int N_PAIRS    = 150;
    localparam int N_LOADS    = 200;
    localparam int N_ALU      = 200;
    localparam int N_OPS      = 2 * WORDS + 2 * N_PAIRS + N_LOADS + N_ALU;
    localparam int CLK_PERIOD = 10;

    logic     clk;
    logic     reset;
    exe_out_t exe;
    wb_t      wb;

    logic [31:0] rng_state = 32'h8493_50a8;
    logic [7:0]  model_mem [0:4*WORDS-1];             // Byte addressed.
    wb_t         expect_q [$];

    mem_stage #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_mem_stage (
        .clk   (clk),
        .reset (reset),
        .exe   (exe),
        .wb    (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ****************************************
    // Random numbers
    // ****************************************

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] rand_addr();
        logic [31:0] a;
        a = rand32();
        a[31:ADDR_WIDTH+2] = '0;                      // Stay inside the banks.
        return a;
    endfunction

    function automatic logic [2:0] store_code();
        case (rand32() % 32'd3)
            32'd0:   return F3_BYTE;
            32'd1:   return F3_HALF;
            default: return F3_WORD;
        endcase
    endfunction

    function automatic logic [2:0] load_code();
        case (rand32() % 32'd5)
            32'd0:   return F3_BYTE;
            32'd1:   return F3_HALF;
            32'd2:   return F3_WORD;
            32'd3:   return F3_BYTE_U;
            default: return F3_HALF_U;
        endcase
    endfunction

    // Halves are aligned to 2, words to 4.
    function automatic logic [31:0] align_load(input logic [31:0] a, input logic [2:0] f3);
        logic [31:0] r;
        r = a;
        if (f3 == F3_HALF || f3 == F3_HALF_U) r[0] = 1'b0;
        if (f3 == F3_WORD) r[1:0] = 2'b00;
        return r;
    endfunction

    // ****************************************
    // Operation builders
    // ****************************************

    function automatic exe_out_t base_op();
        exe_out_t e;
        e              = '0;
        e.alu_out      = rand32();
        e.fp_result    = rand32();
        e.pc           = rand32();
        e.store_data   = rand32();
        e.write_addr   = 5'(rand32());
        e.f_write_addr = 5'(rand32());
        e.funct3       = 3'(rand32());
        return e;
    endfunction

    function automatic exe_out_t store_op(input logic [31:0] a, input logic [2:0] f3);
        exe_out_t e;
        e           = base_op();
        e.alu_out   = a;
        e.funct3    = f3;
        e.mem_write = 1'b1;
        return e;
    endfunction

    function automatic exe_out_t load_op(input logic [31:0] a, input logic [2:0] f3);
        exe_out_t    e;
        logic [31:0] r;
        e            = base_op();
        r            = rand32();
        e.alu_out    = a;
        e.funct3     = f3;
        e.mem_read   = 1'b1;
        e.mem_to_reg = 1'b1;
        e.rd_src     = r[0];                          // Must lose to the load.
        if (f3 == F3_WORD && r[1]) begin              // FLW.
            e.is_float    = 1'b1;
            e.f_reg_write = 1'b1;
        end else begin
            e.reg_write = 1'b1;
        end
        return e;
    endfunction

    function automatic exe_out_t alu_op();
        exe_out_t    e;
        logic [31:0] r;
        e             = base_op();
        r             = rand32();
        e.rd_src      = r[0];
        e.is_float    = r[1];
        e.reg_write   = r[2];
        e.f_reg_write = r[3];
        return e;
    endfunction

    // ****************************************
    // Reference model
    // ****************************************

    function automatic logic [31:0] load_value(input logic [31:0] a, input logic [2:0] f3);
        mem_word_u             w;
        logic [ADDR_WIDTH-1:0] widx;
        logic [7:0]            b;
        logic [15:0]           h;
        widx       = a[ADDR_WIDTH+1:2];
        w.bytes[0] = model_mem[{widx, 2'd0}];
        w.bytes[1] = model_mem[{widx, 2'd1}];
        w.bytes[2] = model_mem[{widx, 2'd2}];
        w.bytes[3] = model_mem[{widx, 2'd3}];
        b = w.bytes[a[1:0]];
        h = {w.bytes[{a[1], 1'b1}], w.bytes[{a[1], 1'b0}]};
        case (f3)
            F3_BYTE:   return {{24{b[7]}}, b};
            F3_HALF:   return {{16{h[15]}}, h};
            F3_BYTE_U: return {24'd0, b};
            F3_HALF_U: return {16'd0, h};
            default:   return w;
        endcase
    endfunction

    task automatic model_store(input logic [31:0] a, input logic [2:0] f3,
                               input logic [31:0] sd);
        logic [ADDR_WIDTH-1:0] widx;
        widx = a[ADDR_WIDTH+1:2];
        case (f3)
            F3_BYTE: model_mem[{widx, a[1:0]}] = sd[7:0];
            F3_HALF: begin                            // Bit 1 picks the half.
                model_mem[{widx, a[1], 1'b0}] = sd[7:0];
                model_mem[{widx, a[1], 1'b1}] = sd[15:8];
            end
            default: begin
                model_mem[{widx, 2'd0}] = sd[7:0];
                model_mem[{widx, 2'd1}] = sd[15:8];
                model_mem[{widx, 2'd2}] = sd[23:16];
                model_mem[{widx, 2'd3}] = sd[31:24];
            end
        endcase
    endtask

    // Predict the result, update the model and drive the operation.
    task automatic issue(input exe_out_t e);
        wb_t w;
        w.reg_write    = e.reg_write;
        w.f_reg_write  = e.f_reg_write;
        w.write_addr   = e.write_addr;
        w.f_write_addr = e.f_write_addr;
        if (e.mem_to_reg) w.data = load_value(e.alu_out, e.funct3);
        else if (e.rd_src) w.data = e.pc + 32'd4;
        else if (e.is_float) w.data = e.fp_result;
        else w.data = e.alu_out;
        if (e.mem_write) model_store(e.alu_out, e.funct3, e.store_data);
        exe = e;
        expect_q.push_back(w);
    endtask

    // ****************************************
    // Checking
    // ****************************************

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, expected);
            $display("CHECKS FAILED");
            $fatal(1, "Stopping at the first mismatch.");
        end
    endtask

    task automatic check_wb(input wb_t expected);
        check_value("wb.reg_write", 32'(wb.reg_write), 32'(expected.reg_write));
        check_value("wb.f_reg_write", 32'(wb.f_reg_write), 32'(expected.f_reg_write));
        check_value("wb.write_addr", 32'(wb.write_addr), 32'(expected.write_addr));
        check_value("wb.f_write_addr", 32'(wb.f_write_addr), 32'(expected.f_write_addr));
        check_value("wb.data", wb.data, expected.data);
    endtask

    task automatic check_idle();
        check_value("wb.reg_write", 32'(wb.reg_write), 32'd0);
        check_value("wb.f_reg_write", 32'(wb.f_reg_write), 32'd0);
        check_value("wb.data", wb.data, 32'd0);
    endtask

    // Result of the item issued two cycles ago is checked here.
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (expect_q.size() == 2) check_wb(expect_q.pop_front());
    endtask

    initial begin
        #((N_OPS + 20) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d ns.", (N_OPS + 20) * CLK_PERIOD);
        $display("CHECKS FAILED");
        $fatal(1, "Watchdog expired.");
    end

    // ****************************************
    // Stimulus
    // ****************************************

    initial begin
        logic [31:0] addr;
        logic [2:0]  f3;
        exe   = '0;
        reset = 1'b1;
        repeat (5) begin
            @(posedge clk);
            #1;
            check_idle();
        end
        reset = 1'b0;
        @(posedge clk);
        #1;
        check_idle();                                 // Right after release.

        // Fill every word so no load sees an unwritten location.
        for (int i = 0; i < WORDS; i++) begin
            next_cycle();
            issue(store_op(32'(i) << 2, F3_WORD));
        end

        // Sized store, then a word load of the same word in the next cycle.
        for (int i = 0; i < N_PAIRS; i++) begin
            addr = rand_addr();
            next_cycle();
            issue(store_op(addr, store_code()));
            next_cycle();
            issue(load_op({addr[31:2], 2'b00}, F3_WORD));
        end

        for (int i = 0; i < N_LOADS; i++) begin
            f3 = load_code();
            next_cycle();
            issue(load_op(align_load(rand_addr(), f3), f3));
        end

        for (int i = 0; i < N_ALU; i++) begin
            next_cycle();
            issue(alu_op());
        end

        // Read back all words to show the ALU phase left memory alone.
        for (int i = 0; i < WORDS; i++) begin
            next_cycle();
            issue(load_op(32'(i) << 2, F3_WORD));
        end

        while (expect_q.size() > 0) begin
            @(posedge clk);
            #1;
            exe = '0;
            check_wb(expect_q.pop_front());
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- verilog.f
mem_pkg.sv
pipe_pkg.sv
exe_mem_reg.sv
data_bank.sv
load_format.sv
mem_stage.sv
tb_mem_stage.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mem_stage -f verilog.f -o sim_mem_stage

./obj_dir/sim_mem_stage 2>&1 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed."
    exit 1
fi
